// ==== logic/abuf_pkg.sv ====
`default_nettype none

package abuf_pkg;

  // ==========================================================
  // Datapath widths
  // ==========================================================

  // One instruction parcel, a compressed instruction or half of a full one
  localparam int PARCEL_BITS = 16;

  // Memory word, split into an even (low) and an odd (high) parcel
  localparam int WORD_BITS = 32;

  // Assembled instruction window returned to the fetcher
  localparam int INSTR_BITS = 32;

  // ==========================================================
  // Refill FSM
  // ==========================================================

  // RF_SECOND marks a double miss with the first line already written
  typedef enum logic [0:0] {
    RF_IDLE   = 1'b0,
    RF_SECOND = 1'b1
  } refill_state_e;

endpackage

`default_nettype wire

// ==== logic/line_lookup_if.sv ====
`default_nettype none

// Lookup result for the line of the fetch address and the line after it
interface line_lookup_if #(
  parameter int IDX_W  = 2,
  parameter int WSEL_W = 2
) ();

  // Set index of the line holding the fetch address
  logic [IDX_W-1:0]  cur_idx;
  // Set index of the line supplying the even parcel
  logic [IDX_W-1:0]  nxt_idx;
  // Misses, only ever high while a fetch is requested
  logic              cur_miss;
  logic              nxt_miss;
  // Word within the line and halfword within the word
  logic [WSEL_W-1:0] word_sel;
  logic              half_sel;
  // Fetch address sits on the last halfword of a line
  logic              line_cross;

  // Tag store side
  modport source (
    output cur_idx, nxt_idx, cur_miss, nxt_miss, word_sel, half_sel, line_cross
  );

  // Banks, refill control and assembler
  modport sink (
    input cur_idx, nxt_idx, cur_miss, nxt_miss, word_sel, half_sel, line_cross
  );

endinterface

`default_nettype wire

// ==== logic/refill_if.sv ====
`default_nettype none

// Fill enables and refill status from the refill control
interface refill_if
  import abuf_pkg::*;
();

  // Write the response line into the cur line slot
  logic          fill_cur;
  // Write the response line into the nxt line slot
  logic          fill_nxt;
  // Memory response pulse
  logic          res_valid;
  // Current refill FSM state
  refill_state_e state;

  // Refill control side
  modport source (output fill_cur, fill_nxt, res_valid, state);

  // Tag store, banks and assembler
  modport sink (input fill_cur, fill_nxt, res_valid, state);

endinterface

`default_nettype wire

// ==== logic/abuf_tag_store.sv ====
`default_nettype none

module abuf_tag_store
  import abuf_pkg::*;
#(
  parameter int CACHE_BITS = 512,
  parameter int BLK_BITS   = 128,
  parameter int XLEN       = 32
) (
  input  wire              clk_i,
  input  wire              reset_i,
  input  wire              flush_i,
  input  wire              fetch_valid_i,
  input  wire [XLEN-1:0]   fetch_addr_i,
  line_lookup_if.source    lookup,
  refill_if.sink           refill
);

  // Geometry derived from capacity and line size
  localparam int NUM_SET = CACHE_BITS / BLK_BITS;
  localparam int IDX_W   = $clog2(NUM_SET);
  localparam int OFF_W   = $clog2(BLK_BITS / 8);
  localparam int TAG_W   = XLEN - IDX_W - OFF_W;
  localparam int WSEL_W  = $clog2(BLK_BITS / WORD_BITS);

  logic [TAG_W-1:0]  tag_q [NUM_SET];
  logic [NUM_SET-1:0] tag_vld_q;

  logic [IDX_W-1:0]  cur_idx;
  logic [IDX_W-1:0]  nxt_idx;
  logic              idx_wrap;
  logic [TAG_W-1:0]  cur_tag;
  logic [TAG_W-1:0]  nxt_tag;
  logic [WSEL_W-1:0] word_sel;
  logic              half_sel;
  logic              line_cross;
  logic              cur_hit;
  logic              nxt_hit;

  // ==========================================================
  // Address decode
  // ==========================================================

  always_comb begin
    half_sel   = fetch_addr_i[1];
    word_sel   = fetch_addr_i[OFF_W-1:2];
    // Last halfword of the line, the upper parcel lives in the next line
    line_cross = &{word_sel, half_sel};

    cur_idx = fetch_addr_i[IDX_W+OFF_W-1:OFF_W];
    cur_tag = fetch_addr_i[XLEN-1:IDX_W+OFF_W];

    // Next line index, a wrap past the last set bumps the tag
    {idx_wrap, nxt_idx} = {1'b0, cur_idx} + (IDX_W + 1)'(line_cross);
    nxt_tag = idx_wrap ? cur_tag + 1'b1 : cur_tag;
  end

  // ==========================================================
  // Tag compare
  // ==========================================================

  assign cur_hit = tag_vld_q[cur_idx] && (tag_q[cur_idx] == cur_tag);
  assign nxt_hit = tag_vld_q[nxt_idx] && (tag_q[nxt_idx] == nxt_tag);

  assign lookup.cur_idx    = cur_idx;
  assign lookup.nxt_idx    = nxt_idx;
  assign lookup.cur_miss   = fetch_valid_i && !cur_hit;
  assign lookup.nxt_miss   = fetch_valid_i && !nxt_hit;
  assign lookup.word_sel   = word_sel;
  assign lookup.half_sel   = half_sel;
  assign lookup.line_cross = line_cross;

  // ==========================================================
  // Tag RAM update
  // ==========================================================

  // Valid bits, cleared on reset and flush
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      tag_vld_q <= '0;
    end else if (refill.fill_cur) begin
      tag_vld_q[cur_idx] <= 1'b1;
    end else if (refill.fill_nxt) begin
      tag_vld_q[nxt_idx] <= 1'b1;
    end
  end

  // Tag storage itself
  always_ff @(posedge clk_i) begin
    if (refill.fill_cur) begin
      tag_q[cur_idx] <= cur_tag;
    end else if (refill.fill_nxt) begin
      tag_q[nxt_idx] <= nxt_tag;
    end
  end

endmodule

`default_nettype wire

// ==== logic/abuf_parcel_banks.sv ====
`default_nettype none

module abuf_parcel_banks
  import abuf_pkg::*;
#(
  parameter int CACHE_BITS = 512,
  parameter int BLK_BITS   = 128
) (
  input  wire                                      clk_i,
  line_lookup_if.sink                              lookup,
  refill_if.sink                                   refill,
  input  wire [BLK_BITS-1:0]                       mem_res_blk_i,
  output logic [BLK_BITS/WORD_BITS-1:0][PARCEL_BITS-1:0] even_parcels_o,
  output logic [BLK_BITS/WORD_BITS-1:0][PARCEL_BITS-1:0] odd_parcels_o
);

  localparam int NUM_SET   = CACHE_BITS / BLK_BITS;
  localparam int IDX_W     = $clog2(NUM_SET);
  localparam int NUM_WORDS = BLK_BITS / WORD_BITS;

  // One RAM per word position in each bank
  logic [PARCEL_BITS-1:0] even_ram [NUM_WORDS][NUM_SET];
  logic [PARCEL_BITS-1:0] odd_ram  [NUM_WORDS][NUM_SET];

  logic [NUM_WORDS-1:0][WORD_BITS-1:0] res_words;
  logic                                wr_en;
  logic [IDX_W-1:0]                    wr_idx;

  // Response line viewed as words
  assign res_words = mem_res_blk_i;

  assign wr_en = refill.fill_cur || refill.fill_nxt;

  // Both banks take the index of the line being filled
  assign wr_idx = refill.fill_cur ? lookup.cur_idx : lookup.nxt_idx;

  // ==========================================================
  // Bank write and read
  // ==========================================================

  for (genvar w = 0; w < NUM_WORDS; w++) begin : gen_word
    // Low halfword to the even bank, high halfword to the odd bank
    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        even_ram[w][wr_idx] <= res_words[w][PARCEL_BITS-1:0];
        odd_ram[w][wr_idx]  <= res_words[w][WORD_BITS-1:PARCEL_BITS];
      end
    end

    // Even parcels from the nxt line
    assign even_parcels_o[w] = even_ram[w][lookup.nxt_idx];
    // Odd parcels from the cur line
    assign odd_parcels_o[w]  = odd_ram[w][lookup.cur_idx];
  end

endmodule

`default_nettype wire

// ==== logic/abuf_refill_ctrl.sv ====
`default_nettype none

module abuf_refill_ctrl
  import abuf_pkg::*;
#(
  parameter int BLK_BITS = 128,
  parameter int XLEN     = 32
) (
  input  wire              clk_i,
  input  wire              reset_i,
  input  wire              flush_i,
  input  wire [XLEN-1:0]   fetch_addr_i,
  input  wire              mem_res_valid_i,
  line_lookup_if.sink      lookup,
  refill_if.source         refill,
  output logic             mem_req_valid_o,
  output logic [XLEN-1:0]  mem_req_addr_o
);

  // Line size in bytes, also the step to the next line
  localparam logic [XLEN-1:0] LINE_BYTES = XLEN'(BLK_BITS / 8);

  refill_state_e state_q;
  refill_state_e state_d;

  logic            double_miss;
  logic            any_miss;
  logic [XLEN-1:0] line_base;

  assign any_miss    = lookup.cur_miss || lookup.nxt_miss;
  // Both lines of a line-crossing fetch are absent
  assign double_miss = lookup.line_cross && lookup.cur_miss && lookup.nxt_miss;

  // ==========================================================
  // Refill FSM
  // ==========================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE: begin
        // First line of a double miss arrives, second still to come
        if (mem_res_valid_i && double_miss) begin
          state_d = RF_SECOND;
        end
      end
      RF_SECOND: begin
        if (mem_res_valid_i) begin
          state_d = RF_IDLE;
        end
      end
      default: state_d = RF_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      state_q <= RF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==========================================================
  // Memory request
  // ==========================================================

  // Level request, dropped in the response cycle
  assign mem_req_valid_o = any_miss && !mem_res_valid_i;

  assign line_base = fetch_addr_i & ~(LINE_BYTES - 1'b1);

  // Next line once cur is present, cur line base otherwise
  always_comb begin
    if (state_q == RF_SECOND || (!lookup.cur_miss && lookup.nxt_miss)) begin
      mem_req_addr_o = line_base + LINE_BYTES;
    end else begin
      mem_req_addr_o = line_base;
    end
  end

  // Fill enables, cur line always first
  assign refill.fill_cur  = mem_res_valid_i && lookup.cur_miss;
  assign refill.fill_nxt  = mem_res_valid_i && !lookup.cur_miss && lookup.nxt_miss;
  assign refill.res_valid = mem_res_valid_i;
  assign refill.state     = state_q;

endmodule

`default_nettype wire

// ==== logic/abuf_instr_assemble.sv ====
`default_nettype none

module abuf_instr_assemble
  import abuf_pkg::*;
#(
  parameter int BLK_BITS = 128
) (
  input  wire                                            fetch_valid_i,
  line_lookup_if.sink                                    lookup,
  refill_if.sink                                         refill,
  input  wire [BLK_BITS/WORD_BITS-1:0][PARCEL_BITS-1:0]  even_parcels_i,
  input  wire [BLK_BITS/WORD_BITS-1:0][PARCEL_BITS-1:0]  odd_parcels_i,
  input  wire [BLK_BITS-1:0]                             mem_res_blk_i,
  output logic                                           instr_valid_o,
  output logic [INSTR_BITS-1:0]                          instr_o,
  output logic                                           instr_miss_o,
  output logic                                           waiting_second_o
);

  localparam int NUM_WORDS = BLK_BITS / WORD_BITS;
  localparam int WSEL_W    = $clog2(NUM_WORDS);

  logic [NUM_WORDS-1:0][WORD_BITS-1:0] res_words;
  logic [WSEL_W-1:0]                   even_word;
  logic [PARCEL_BITS-1:0]              even_parcel;
  logic [PARCEL_BITS-1:0]              odd_parcel;
  logic                                any_miss;
  logic                                first_of_double;

  assign res_words = mem_res_blk_i;

  // ==========================================================
  // Parcel select
  // ==========================================================

  // Even parcel sits one word up on a halfword address, word 0 of next line on a crossing
  assign even_word = lookup.line_cross ? '0 : lookup.word_sel + WSEL_W'(lookup.half_sel);

  always_comb begin
    // Odd parcel
    if (refill.res_valid && lookup.cur_miss) begin
      odd_parcel = res_words[lookup.word_sel][WORD_BITS-1:PARCEL_BITS];
    end else begin
      odd_parcel = odd_parcels_i[lookup.word_sel];
    end

    // Even parcel
    if (refill.res_valid && lookup.nxt_miss) begin
      even_parcel = res_words[even_word][PARCEL_BITS-1:0];
    end else begin
      even_parcel = even_parcels_i[even_word];
    end
  end

  // Halfword order follows address bit 1
  assign instr_o = lookup.half_sel ? {even_parcel, odd_parcel} : {odd_parcel, even_parcel};

  // ==========================================================
  // Valid and status
  // ==========================================================

  assign any_miss = lookup.cur_miss || lookup.nxt_miss;

  // First response of a double miss only fills the cur line
  assign first_of_double = (refill.state == RF_IDLE) && lookup.line_cross &&
                           lookup.cur_miss && lookup.nxt_miss;

  always_comb begin
    if (fetch_valid_i && !any_miss) begin
      // Both lines hit
      instr_valid_o = 1'b1;
    end else begin
      // Response that completes the last missing line
      instr_valid_o = refill.res_valid && any_miss && !first_of_double;
    end
  end

  assign instr_miss_o     = any_miss;
  assign waiting_second_o = (refill.state == RF_SECOND);

endmodule

`default_nettype wire

// ==== logic/align_buffer.sv ====
`default_nettype none

module align_buffer
  import abuf_pkg::*;
#(
  parameter int CACHE_BITS = 512,
  parameter int BLK_BITS   = 128,
  parameter int XLEN       = 32
) (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   flush_i,
  // Fetch request
  input  wire                   fetch_valid_i,
  input  wire [XLEN-1:0]        fetch_addr_i,
  // Memory request
  output logic                  mem_req_valid_o,
  output logic [XLEN-1:0]       mem_req_addr_o,
  // Memory response
  input  wire                   mem_res_valid_i,
  input  wire [BLK_BITS-1:0]    mem_res_blk_i,
  // Instruction out
  output logic                  instr_valid_o,
  output logic [INSTR_BITS-1:0] instr_o,
  output logic                  instr_miss_o,
  output logic                  waiting_second_o
);

  localparam int NUM_SET   = CACHE_BITS / BLK_BITS;
  localparam int IDX_W     = $clog2(NUM_SET);
  localparam int NUM_WORDS = BLK_BITS / WORD_BITS;
  localparam int WSEL_W    = $clog2(NUM_WORDS);

  // Bank parcels toward the assembler
  logic [NUM_WORDS-1:0][PARCEL_BITS-1:0] even_parcels;
  logic [NUM_WORDS-1:0][PARCEL_BITS-1:0] odd_parcels;

  line_lookup_if #(.IDX_W(IDX_W), .WSEL_W(WSEL_W)) lookup_bus ();
  refill_if refill_bus ();

  // ==========================================================
  // Lookup and storage
  // ==========================================================

  abuf_tag_store #(
    .CACHE_BITS (CACHE_BITS),
    .BLK_BITS   (BLK_BITS),
    .XLEN       (XLEN)
  ) tag_store_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .lookup        (lookup_bus.source),
    .refill        (refill_bus.sink)
  );

  abuf_parcel_banks #(
    .CACHE_BITS (CACHE_BITS),
    .BLK_BITS   (BLK_BITS)
  ) parcel_banks_inst (
    .clk_i          (clk_i),
    .lookup         (lookup_bus.sink),
    .refill         (refill_bus.sink),
    .mem_res_blk_i  (mem_res_blk_i),
    .even_parcels_o (even_parcels),
    .odd_parcels_o  (odd_parcels)
  );

  // ==========================================================
  // Refill and output
  // ==========================================================

  abuf_refill_ctrl #(
    .BLK_BITS (BLK_BITS),
    .XLEN     (XLEN)
  ) refill_ctrl_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flush_i         (flush_i),
    .fetch_addr_i    (fetch_addr_i),
    .mem_res_valid_i (mem_res_valid_i),
    .lookup          (lookup_bus.sink),
    .refill          (refill_bus.source),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o)
  );

  abuf_instr_assemble #(
    .BLK_BITS (BLK_BITS)
  ) instr_assemble_inst (
    .fetch_valid_i    (fetch_valid_i),
    .lookup           (lookup_bus.sink),
    .refill           (refill_bus.sink),
    .even_parcels_i   (even_parcels),
    .odd_parcels_i    (odd_parcels),
    .mem_res_blk_i    (mem_res_blk_i),
    .instr_valid_o    (instr_valid_o),
    .instr_o          (instr_o),
    .instr_miss_o     (instr_miss_o),
    .waiting_second_o (waiting_second_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

// Free running clock, starts low
module tb_clock_gen #(
  parameter int PERIOD = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== dv/align_buffer_tb.sv ====
`default_nettype none

module align_buffer_tb
  import abuf_pkg::*;
();

  localparam int XLEN          = 32;
  localparam int BLK_BITS      = 128;
  localparam int FETCH_TIMEOUT = 100;

  logic                  clk_i;
  logic                  reset_i;
  logic                  flush_i;
  logic                  fetch_valid_i;
  logic [XLEN-1:0]       fetch_addr_i;
  logic                  mem_req_valid_o;
  logic [XLEN-1:0]       mem_req_addr_o;
  logic                  mem_res_valid_i;
  logic [BLK_BITS-1:0]   mem_res_blk_i;
  logic                  instr_valid_o;
  logic [INSTR_BITS-1:0] instr_o;
  logic                  instr_miss_o;
  logic                  waiting_second_o;

  // Shared by memory latency and random addresses
  integer seed = 24852;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int test_start   = 0;
  bit timed_out    = 1'b0;

  // Memory model bookkeeping
  int              req_count  = 0;
  int              resp_count = 0;
  logic [XLEN-1:0] req_addrs[$];

  // Observations of the last fetch
  bit              got_ok;
  logic [31:0]     got_instr;
  logic            got_miss;
  int              got_reqs;
  int              got_resps;
  int              got_cycles;
  int              win_cycles;
  int              win_bad;

  tb_clock_gen #(.PERIOD(10)) clock_gen_inst (.clk_o(clk_i));

  align_buffer #(
    .CACHE_BITS (512),
    .BLK_BITS   (BLK_BITS),
    .XLEN       (XLEN)
  ) align_buffer_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_addr_i     (fetch_addr_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_res_valid_i  (mem_res_valid_i),
    .mem_res_blk_i    (mem_res_blk_i),
    .instr_valid_o    (instr_valid_o),
    .instr_o          (instr_o),
    .instr_miss_o     (instr_miss_o),
    .waiting_second_o (waiting_second_o)
  );

  // ==========================================================
  // Reference memory contents
  // ==========================================================

  // Halfword at a byte address is the low 16 bits of a/2 XORed with a mask
  function automatic logic [15:0] half_at(input logic [31:0] a);
    half_at = a[16:1] ^ 16'hA5C3;
  endfunction

  // Instruction window with the upper halfword taken from a+2
  function automatic logic [31:0] expect_instr(input logic [31:0] a);
    expect_instr = {half_at(a + 32'd2), half_at(a)};
  endfunction

  function automatic logic [BLK_BITS-1:0] line_data(input logic [31:0] base);
    logic [BLK_BITS-1:0] blk;
    blk = '0;
    for (int w = 0; w < BLK_BITS / 32; w++) begin
      blk[32*w +: 32] = {half_at(base + 32'(4 * w) + 32'd2), half_at(base + 32'(4 * w))};
    end
    return blk;
  endfunction

  // ==========================================================
  // Memory model
  // ==========================================================

  // One response pulse per request after 1 to 6 cycles
  initial begin
    int unsigned     latency;
    logic [XLEN-1:0] addr;
    mem_res_valid_i = 1'b0;
    mem_res_blk_i   = '0;
    forever begin
      @(negedge clk_i);
      if (mem_req_valid_o === 1'b1) begin
        addr = mem_req_addr_o;
        req_addrs.push_back(addr);
        req_count++;
        latency = 1 + ($unsigned($random(seed)) % 6);
        repeat (latency) @(posedge clk_i);
        #1;
        mem_res_valid_i = 1'b1;
        mem_res_blk_i   = line_data(addr);
        resp_count++;
        @(posedge clk_i);
        #1;
        mem_res_valid_i = 1'b0;
      end
    end
  end

  // ==========================================================
  // Helpers
  // ==========================================================

  task automatic next_drive_point();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s %s: expected %h, actual %h", test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input string test, input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("FAIL %s: %s", test, msg);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_start) begin
      $display("%-20s ok", name);
    end else begin
      tests_failed++;
      $display("%-20s %0d errors", name, errors - test_start);
    end
  endtask

  // Holds a fetch until the instruction is valid
  // Entered and left at a drive point
  task automatic run_fetch(input logic [31:0] addr);
    int req_start;
    int resp_start;
    int cycles;
    bit done;
    req_start  = req_count;
    resp_start = resp_count;
    win_cycles = 0;
    win_bad    = 0;
    cycles     = 0;
    done       = 1'b0;
    fetch_valid_i = 1'b1;
    fetch_addr_i  = addr;
    @(negedge clk_i);
    got_miss = instr_miss_o;
    while (!done && cycles < FETCH_TIMEOUT) begin
      if (instr_valid_o === 1'b1) begin
        done = 1'b1;
      end else begin
        // Gap between the first and second response of a double miss
        if (resp_count - resp_start == 1 && mem_res_valid_i == 1'b0) begin
          win_cycles++;
          if (waiting_second_o !== 1'b1) begin
            win_bad++;
          end
        end
        cycles++;
        @(negedge clk_i);
      end
    end
    got_ok     = done;
    got_instr  = instr_o;
    got_resps  = resp_count - resp_start;
    got_cycles = cycles;
    next_drive_point();
    fetch_valid_i = 1'b0;
    got_reqs = req_count - req_start;
    if (!done) begin
      $display("Timeout: no valid instruction for address %h within %0d cycles",
               addr, FETCH_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // ==========================================================
  // Tests
  // ==========================================================

  task automatic cold_fetch();
    test_start = errors;
    check_true("cold_fetch", !mem_req_valid_o && !waiting_second_o,
               "request or wait flag high after reset");
    run_fetch(32'h0000_0040);
    if (!got_ok) return;
    check_value("cold_fetch", "request count", 32'd1, got_reqs);
    check_value("cold_fetch", "request address", 32'h40, req_addrs[req_addrs.size()-1]);
    check_true("cold_fetch", got_miss, "miss flag low on a cold fetch");
    check_value("cold_fetch", "instruction", expect_instr(32'h40), got_instr);
    // Same address again hits in the request cycle
    run_fetch(32'h0000_0040);
    if (!got_ok) return;
    check_value("cold_fetch", "refetch request count", 32'd0, got_reqs);
    check_value("cold_fetch", "refetch wait cycles", 32'd0, got_cycles);
    check_true("cold_fetch", !got_miss, "miss flag high on a hit");
    check_value("cold_fetch", "refetch instruction", expect_instr(32'h40), got_instr);
    report_test("cold_fetch");
  endtask

  task automatic half_offset_fetch();
    test_start = errors;
    run_fetch(32'h0000_0046);
    if (!got_ok) return;
    check_value("half_offset_fetch", "request count", 32'd0, got_reqs);
    check_value("half_offset_fetch", "instruction", expect_instr(32'h46), got_instr);
    report_test("half_offset_fetch");
  endtask

  task automatic double_miss_fetch();
    int base;
    test_start = errors;
    base = req_addrs.size();
    // Offset 14 of line 0x80 with the upper parcel in line 0x90
    run_fetch(32'h0000_008E);
    if (!got_ok) return;
    check_value("double_miss_fetch", "request count", 32'd2, got_reqs);
    check_value("double_miss_fetch", "first request", 32'h80, req_addrs[base]);
    check_value("double_miss_fetch", "second request", 32'h90, req_addrs[base+1]);
    check_value("double_miss_fetch", "responses before valid", 32'd2, got_resps);
    check_true("double_miss_fetch", win_cycles > 0, "no cycle between the two responses");
    check_value("double_miss_fetch", "cycles with wait flag low", 32'd0, win_bad);
    check_value("double_miss_fetch", "instruction", expect_instr(32'h8E), got_instr);
    @(negedge clk_i);
    check_true("double_miss_fetch", !waiting_second_o, "wait flag still high after refill");
    next_drive_point();
    report_test("double_miss_fetch");
  endtask

  task automatic next_only_miss_fetch();
    int base;
    test_start = errors;
    base = req_addrs.size();
    // Line 0x90 is present and 0xA0 is not
    run_fetch(32'h0000_009E);
    if (!got_ok) return;
    check_value("next_only_miss", "request count", 32'd1, got_reqs);
    check_value("next_only_miss", "request address", 32'hA0, req_addrs[base]);
    check_value("next_only_miss", "instruction", expect_instr(32'h9E), got_instr);
    report_test("next_only_miss");
  endtask

  task automatic flush_refetch();
    int base;
    test_start = errors;
    run_fetch(32'h0000_0084);
    if (!got_ok) return;
    check_value("flush_refetch", "request count before flush", 32'd0, got_reqs);
    flush_i = 1'b1;
    next_drive_point();
    flush_i = 1'b0;
    base = req_addrs.size();
    run_fetch(32'h0000_0084);
    if (!got_ok) return;
    check_value("flush_refetch", "request count after flush", 32'd1, got_reqs);
    check_value("flush_refetch", "request address", 32'h80, req_addrs[base]);
    check_value("flush_refetch", "instruction", expect_instr(32'h84), got_instr);
    report_test("flush_refetch");
  endtask

  task automatic random_fetch();
    int          base;
    logic [31:0] addr;
    test_start = errors;
    base = req_addrs.size();
    // Halfword addresses in 0x100 to 0x1FF
    for (int i = 0; i < 40; i++) begin
      addr = 32'h100 + ($random(seed) & 32'h0000_00FE);
      run_fetch(addr);
      if (!got_ok) return;
      check_value("random_fetch", "instruction", expect_instr(addr), got_instr);
    end
    for (int i = base; i < req_addrs.size(); i++) begin
      check_value("random_fetch", "request address low bits", 32'd0, req_addrs[i] & 32'hF);
    end
    report_test("random_fetch");
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    reset_i       = 1'b1;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    next_drive_point();

    cold_fetch();
    if (!timed_out) half_offset_fetch();
    if (!timed_out) double_miss_fetch();
    if (!timed_out) next_only_miss_fetch();
    if (!timed_out) flush_refetch();
    if (!timed_out) random_fetch();

    $display("Summary: %0d tests run, %0d failing, %0d errors, timeout %0d",
             tests_run, tests_failed, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/abuf_pkg.sv
logic/line_lookup_if.sv
logic/refill_if.sv
logic/abuf_tag_store.sv
logic/abuf_parcel_banks.sv
logic/abuf_refill_ctrl.sv
logic/abuf_instr_assemble.sv
logic/align_buffer.sv
dv/tb_clock_gen.sv
dv/align_buffer_tb.sv

// ==== Makefile ====
# Verilator build and run for the align buffer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := align_buffer_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides the result, the fail message must be absent and the pass message present
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
